//--- lsu_golden.txt
# kind suffix_b suffix_h sext addr data expected_r_wdata load_misaligned store_misaligned
# data is exu_r_wdata for alu and wsrc otherwise, hex fields without prefix
alu   0 0 0 00000000 deadbeef deadbeef 0 0
alu   0 0 0 00000000 12345678 12345678 0 0
store 0 0 0 00000010 a1b2c3d4 00000000 0 0
load  0 0 0 00000010 00000000 a1b2c3d4 0 0
store 1 0 0 00000020 000000aa 00000000 0 0
store 1 0 0 00000021 123456cc 00000000 0 0
store 1 0 0 00000023 000000ee 00000000 0 0
load  0 0 0 00000020 00000000 ee00ccaa 0 0
store 0 1 0 00000022 0000f00d 00000000 0 0
store 0 1 0 00000021 00009876 00000000 0 0
load  0 0 0 00000020 00000000 f09876aa 0 0
load  1 0 1 00000020 00000000 ffffffaa 0 0
load  1 0 0 00000020 00000000 000000aa 0 0
load  1 0 1 00000021 00000000 00000076 0 0
load  1 0 1 00000023 00000000 fffffff0 0 0
load  1 0 0 00000022 00000000 00000098 0 0
load  0 1 1 00000020 00000000 000076aa 0 0
load  0 1 1 00000022 00000000 fffff098 0 0
load  0 1 0 00000022 00000000 0000f098 0 0
load  0 1 1 00000021 00000000 ffff9876 0 0
store 0 1 0 00000024 abcd1234 00000000 0 0
store 1 0 0 00000026 00000099 00000000 0 0
load  0 0 0 00000024 00000000 00991234 0 0
load  0 0 0 00000012 00000000 00000000 1 0
flush 0 0 0 00000010 55555555 00000000 0 0
store 0 0 0 00000011 11111111 00000000 0 1
flush 0 0 0 00000010 55555555 00000000 0 0
store 0 1 0 00000023 00002222 00000000 0 1
flush 0 0 0 00000010 55555555 00000000 0 0
load  0 1 1 00000013 00000000 00000000 1 0
flush 0 0 0 00000010 55555555 00000000 0 0
load  0 0 0 00000010 00000000 a1b2c3d4 0 0
load  0 0 0 00000020 00000000 f09876aa 0 0
flush 0 0 0 00000010 55555555 00000000 0 0
load  0 0 0 00000010 00000000 a1b2c3d4 0 0
alu   0 0 0 00000000 cafef00d cafef00d 0 0

//--- lsu_subsys.f
lsu_pkg.sv
lsu_stage.sv
lsu_read_channel.sv
lsu_write_channel.sv
axi_data_ram.sv
lsu_top.sv
lsu_tb.sv

//--- Bender.yml
package:
  name: lsu_subsys

sources:
  - lsu_pkg.sv
  - lsu_stage.sv
  - lsu_read_channel.sv
  - lsu_write_channel.sv
  - axi_data_ram.sv
  - lsu_top.sv
  - target: test
    files:
      - lsu_tb.sv

//--- lsu_tb.sv
`timescale 1ns/1ns

module lsu_tb;
  import lsu_pkg::*;

  typedef enum int {op_alu, op_load, op_store, op_flush} op_kind_e;

  logic            clock;
  logic            reset;
  logic            execute_valid;
  logic            ren;
  logic            wen;
  logic            suffix_b;
  logic            suffix_h;
  logic            sext;
  logic            clear_pipeline;
  logic [xlen-1:0] addr;
  logic [xlen-1:0] wsrc;
  logic [xlen-1:0] exu_pc;
  logic [xlen-1:0] exu_r_wdata;
  logic            ls_valid;
  logic [xlen-1:0] lsu_pc;
  logic [xlen-1:0] r_wdata;
  logic            block;
  logic            load_addr_misaligned;
  logic            store_addr_misaligned;

  // golden operations, one entry per line of the file
  op_kind_e        kind_q[$];
  bit              b_q[$], h_q[$], s_q[$], lm_q[$], sm_q[$];
  logic [xlen-1:0] addr_q[$];
  logic [xlen-1:0] data_q[$];
  logic [xlen-1:0] exp_q[$];

  int              num_ops;
  int              data_errors;
  int              fault_errors;
  int              other_errors;
  logic [31:0]     lfsr;

  lsu_top UUT (
    .clock, .reset, .execute_valid, .ren, .wen, .suffix_b, .suffix_h, .sext,
    .clear_pipeline, .addr, .wsrc, .exu_pc, .exu_r_wdata,
    .ls_valid, .lsu_pc, .r_wdata, .block, .load_addr_misaligned, .store_addr_misaligned
  );

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  // ====================
  // helpers
  // ====================

  function automatic logic [31:0] lfsr_step(logic [31:0] state);
    return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
  endfunction

  task automatic idle_gap();
    int gap;
    gap = 0;
    repeat (2) begin
      gap  = (gap << 1) | lfsr[0];  // one lfsr step per bit
      lfsr = lfsr_step(lfsr);
    end
    repeat (gap) @(posedge clock);
  endtask

  task automatic load_golden();
    int fd;
    int n;
    int b, h, s, lm, sm;
    logic [8*8-1:0] tok;
    logic [xlen-1:0] a, d, e;
    logic [8*160-1:0] line_buf;
    fd = $fopen("lsu_golden.txt", "r");
    if (fd == 0) begin
      other_errors++;
      $display("cannot open lsu_golden.txt for reading");
      return;
    end
    while ($fgets(line_buf, fd) != 0) begin
      tok = '0;
      n = $sscanf(line_buf, "%s %d %d %d %h %h %h %d %d", tok, b, h, s, a, d, e, lm, sm);
      if (n < 1 || tok == "#") continue;  // blank line or column legend
      if (n != 9) begin
        other_errors++;
        $display("malformed line in golden file, only %0d fields read", n);
        continue;
      end
      case (tok)
        "alu":   kind_q.push_back(op_alu);
        "load":  kind_q.push_back(op_load);
        "store": kind_q.push_back(op_store);
        "flush": kind_q.push_back(op_flush);
        default: begin
          other_errors++;
          $display("unknown operation kind in golden file");
          continue;
        end
      endcase
      b_q.push_back(b != 0);
      h_q.push_back(h != 0);
      s_q.push_back(s != 0);
      lm_q.push_back(lm != 0);
      sm_q.push_back(sm != 0);
      addr_q.push_back(a);
      data_q.push_back(d);
      exp_q.push_back(e);
    end
    $fclose(fd);
  endtask

  task automatic check_data(input string name, input logic [xlen-1:0] expected,
                            input logic [xlen-1:0] actual);
    if (actual !== expected) begin
      data_errors++;
      $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic check_fault(input string name, input mem_size_e size,
                             input logic exp_ld, input logic exp_st,
                             input logic act_ld, input logic act_st);
    if (act_ld !== exp_ld || act_st !== exp_st) begin
      fault_errors++;
      $display("[ERROR] %s (%s): expected load/store misaligned %b/%b, actual %b/%b",
               name, size.name(), exp_ld, exp_st, act_ld, act_st);
    end
  endtask

  // the operation is taken on the second edge, then execute goes quiet
  task automatic issue(input int i, input logic [xlen-1:0] pc);
    @(posedge clock);
    execute_valid  <= 1'b1;
    ren            <= (kind_q[i] == op_load);
    wen            <= (kind_q[i] == op_store) || (kind_q[i] == op_flush);
    clear_pipeline <= (kind_q[i] == op_flush);
    suffix_b       <= b_q[i];
    suffix_h       <= h_q[i];
    sext           <= s_q[i];
    addr           <= addr_q[i];
    wsrc           <= (kind_q[i] == op_alu) ? '0 : data_q[i];
    exu_r_wdata    <= (kind_q[i] == op_alu) ? data_q[i] : '0;
    exu_pc         <= pc;
    @(posedge clock);
    execute_valid  <= 1'b0;
    clear_pipeline <= 1'b0;
  endtask

  task automatic wait_done(input string name, output bit seen);
    seen = 0;
    for (int n = 0; n < 30 && !seen; n++) begin
      @(negedge clock);
      if (ls_valid || load_addr_misaligned || store_addr_misaligned) seen = 1;
    end
    if (!seen) begin
      other_errors++;
      $display("%s: neither ls_valid nor a fault flag came within 30 cycles", name);
    end
  endtask

  // a flushed operation never completes and leaves the stage idle
  task automatic check_flush(input string name);
    repeat (3) begin
      @(negedge clock);
      if (block || load_addr_misaligned || store_addr_misaligned || ls_valid) begin
        other_errors++;
        $display("%s: stage not idle after the flush", name);
      end
    end
  endtask

  // ====================
  // main sequence
  // ====================

  initial begin
    string name;
    mem_size_e size;
    logic [xlen-1:0] pc;
    bit seen;
    lfsr = 32'hb16b_c4fb;
    data_errors = 0;
    fault_errors = 0;
    other_errors = 0;
    num_ops = 0;
    reset = 1'b1;
    execute_valid = 1'b0;
    ren = 1'b0;
    wen = 1'b0;
    suffix_b = 1'b0;
    suffix_h = 1'b0;
    sext = 1'b0;
    clear_pipeline = 1'b0;
    addr = '0;
    wsrc = '0;
    exu_pc = '0;
    exu_r_wdata = '0;
    load_golden();
    num_ops = kind_q.size();
    repeat (10) @(posedge clock);
    reset <= 1'b0;
    @(negedge clock);
    if (block || ls_valid || load_addr_misaligned || store_addr_misaligned) begin
      other_errors++;
      $display("stage outputs not cleared by reset");
    end
    if (num_ops == 0) begin
      other_errors++;
      $display("golden file holds no operations");
    end
    for (int i = 0; i < num_ops; i++) begin
      name = $sformatf("line %0d %s", i + 1, kind_q[i].name());
      size = b_q[i] ? size_byte : (h_q[i] ? size_half : size_word);
      pc   = 32'h0000_1000 + 4 * i;
      idle_gap();
      issue(i, pc);
      if (kind_q[i] == op_flush) begin
        check_flush(name);
        continue;
      end
      wait_done(name, seen);
      if (!seen) continue;
      check_fault(name, size, lm_q[i], sm_q[i], load_addr_misaligned, store_addr_misaligned);
      if (lm_q[i] || sm_q[i]) begin
        if (!block || ls_valid) begin
          other_errors++;
          $display("%s: faulted access did not hold block without ls_valid", name);
        end
      end else begin
        if (block) begin
          other_errors++;
          $display("%s: block still high during ls_valid", name);
        end
        if (kind_q[i] != op_store) check_data({name, " r_wdata"}, exp_q[i], r_wdata);
        check_data({name, " lsu_pc"}, pc, lsu_pc);
      end
    end
    $display("errors: data %0d, fault %0d, other %0d", data_errors, fault_errors, other_errors);
    if (data_errors + fault_errors + other_errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // watchdog, 40 cycles per golden line plus reset
  initial begin
    wait (num_ops > 0);
    repeat (num_ops * 40 + 20) @(posedge clock);
    $display("timeout: the run did not finish within %0d cycles", num_ops * 40 + 20);
    $display("Test failed");
    $finish;
  end

endmodule

//--- lsu_top.sv
`timescale 1ns/1ns

module lsu_top (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    execute_valid,
  input  logic                    ren,
  input  logic                    wen,
  input  logic                    suffix_b,
  input  logic                    suffix_h,
  input  logic                    sext,
  input  logic                    clear_pipeline,
  input  logic [lsu_pkg::xlen-1:0] addr,
  input  logic [lsu_pkg::xlen-1:0] wsrc,
  input  logic [lsu_pkg::xlen-1:0] exu_pc,
  input  logic [lsu_pkg::xlen-1:0] exu_r_wdata,
  output logic                    ls_valid,
  output logic [lsu_pkg::xlen-1:0] lsu_pc,
  output logic [lsu_pkg::xlen-1:0] r_wdata,
  output logic                    block,
  output logic                    load_addr_misaligned,
  output logic                    store_addr_misaligned
);
  import lsu_pkg::*;

  // stage to channels
  logic            rd_start, wr_start, rd_done, wr_done, op_sext;
  logic [xlen-1:0] op_addr, op_wsrc, load_data;
  mem_size_e       op_size;

  // channels to RAM
  logic                  arvalid, arready, rvalid, rready;
  logic                  awvalid, awready, wvalid, wready, bvalid, bready;
  logic [xlen-1:0]       araddr, rdata, awaddr, wdata;
  logic [2:0]            arsize, awsize;
  logic [strb_w-1:0]     wstrb;
  logic [axi_resp_w-1:0] rresp, bresp;

  lsu_stage u_stage (
    .clock, .reset, .execute_valid, .ren, .wen, .suffix_b, .suffix_h, .sext,
    .clear_pipeline, .addr, .wsrc, .exu_pc, .exu_r_wdata,
    .rd_done, .wr_done, .load_data,
    .ls_valid, .block, .load_addr_misaligned, .store_addr_misaligned,
    .rd_start, .wr_start, .op_sext, .lsu_pc, .r_wdata, .op_addr, .op_wsrc, .op_size
  );

  lsu_read_channel u_read (
    .clock, .reset, .rd_start, .op_addr, .op_size, .op_sext,
    .arready, .rdata, .rresp, .rvalid,
    .arvalid, .araddr, .arsize, .rready, .rd_done, .load_data
  );

  lsu_write_channel u_write (
    .clock, .reset, .wr_start, .op_addr, .op_wsrc, .op_size,
    .awready, .wready, .bresp, .bvalid,
    .awvalid, .awaddr, .awsize, .wvalid, .wdata, .wstrb, .bready, .wr_done
  );

  // size fields leave the channels for the bus, the word RAM ignores them
  axi_data_ram u_ram (
    .clock, .reset, .arvalid, .araddr, .rready,
    .awvalid, .awaddr, .wvalid, .wdata, .wstrb, .bready,
    .arready, .rvalid, .rdata, .rresp, .awready, .wready, .bvalid, .bresp
  );

endmodule

//--- axi_data_ram.sv
`timescale 1ns/1ns

module axi_data_ram (
  input  logic                          clock,
  input  logic                          reset,
  input  logic                          arvalid,
  input  logic [lsu_pkg::xlen-1:0]       araddr,
  input  logic                          rready,
  input  logic                          awvalid,
  input  logic [lsu_pkg::xlen-1:0]       awaddr,
  input  logic                          wvalid,
  input  logic [lsu_pkg::xlen-1:0]       wdata,
  input  logic [lsu_pkg::strb_w-1:0]     wstrb,
  input  logic                          bready,
  output logic                          arready,
  output logic                          rvalid,
  output logic [lsu_pkg::xlen-1:0]       rdata,
  output logic [lsu_pkg::axi_resp_w-1:0] rresp,
  output logic                          awready,
  output logic                          wready,
  output logic                          bvalid,
  output logic [lsu_pkg::axi_resp_w-1:0] bresp
);
  import lsu_pkg::*;

  logic [xlen-1:0] mem [ram_words];
  logic [ram_aw-1:0] rd_idx;
  logic [ram_aw-1:0] wr_idx;
  logic rd_fire;
  logic wr_fire;

  // word index drops the byte offset, upper address bits wrap
  assign rd_idx  = araddr[ram_aw+1:2];
  assign wr_idx  = awaddr[ram_aw+1:2];
  assign rd_fire = arvalid & arready;
  assign wr_fire = awvalid & awready & wvalid & wready;

  assign rresp = resp_okay;
  assign bresp = resp_okay;

  // ====================
  // read channel
  // ====================

  always_ff @(posedge clock) begin
    if (reset) begin
      arready <= 1'b0;
      rvalid  <= 1'b0;
    end else begin
      arready <= arvalid & ~arready & ~rvalid;  // single-cycle ready pulse
      if (rd_fire) rvalid <= 1'b1;
      else if (rvalid && rready) rvalid <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (rd_fire) rdata <= mem[rd_idx];
  end

  // ====================
  // write channel
  // ====================

  // both readies go up together once address and data are both offered
  always_ff @(posedge clock) begin
    if (reset) begin
      awready <= 1'b0;
      wready  <= 1'b0;
      bvalid  <= 1'b0;
    end else begin
      awready <= awvalid & wvalid & ~awready & ~bvalid;
      wready  <= awvalid & wvalid & ~wready & ~bvalid;
      if (wr_fire) bvalid <= 1'b1;
      else if (bvalid && bready) bvalid <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < ram_words; i++) begin
        mem[i] <= '0;
      end
    end else if (wr_fire) begin
      for (int b = 0; b < strb_w; b++) begin
        if (wstrb[b]) mem[wr_idx][8*b +: 8] <= wdata[8*b +: 8];
      end
    end
  end

endmodule

//--- lsu_write_channel.sv
`timescale 1ns/1ns

module lsu_write_channel (
  input  logic                          clock,
  input  logic                          reset,
  input  logic                          wr_start,
  input  logic [lsu_pkg::xlen-1:0]       op_addr,
  input  logic [lsu_pkg::xlen-1:0]       op_wsrc,
  input  lsu_pkg::mem_size_e            op_size,
  input  logic                          awready,
  input  logic                          wready,
  input  logic [lsu_pkg::axi_resp_w-1:0] bresp,
  input  logic                          bvalid,
  output logic                          awvalid,
  output logic [lsu_pkg::xlen-1:0]       awaddr,
  output logic [2:0]                    awsize,
  output logic                          wvalid,
  output logic [lsu_pkg::xlen-1:0]       wdata,
  output logic [lsu_pkg::strb_w-1:0]     wstrb,
  output logic                          bready,
  output logic                          wr_done
);
  import lsu_pkg::*;

  logic aw_fire;
  logic w_fire;

  assign aw_fire = awvalid & awready;
  assign w_fire  = wvalid & wready;

  // ====================
  // handshake
  // ====================

  // address and data rise together, each falls on its own transfer
  always_ff @(posedge clock) begin
    if (reset) begin
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
      bready  <= 1'b0;
    end else begin
      if (wr_start) begin
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
      end else begin
        if (aw_fire) awvalid <= 1'b0;
        if (w_fire) wvalid <= 1'b0;
      end
      if (w_fire) begin
        bready <= 1'b1;  // response is only wanted once the data beat is gone
      end else if (bready && bvalid) begin
        bready <= 1'b0;
      end
    end
  end

  // a slave error still ends the store, the stage has no trap for it
  assign wr_done = bready & bvalid;

  // ====================
  // lane placement
  // ====================

  assign awaddr = op_addr;
  assign awsize = axi_size(op_size);
  assign wdata  = op_wsrc << {op_addr[1:0], 3'b000};
  assign wstrb  = base_strobe(op_size) << op_addr[1:0];

endmodule

//--- lsu_read_channel.sv
`timescale 1ns/1ns

module lsu_read_channel (
  input  logic                          clock,
  input  logic                          reset,
  input  logic                          rd_start,
  input  logic [lsu_pkg::xlen-1:0]       op_addr,
  input  lsu_pkg::mem_size_e            op_size,
  input  logic                          op_sext,
  input  logic                          arready,
  input  logic [lsu_pkg::xlen-1:0]       rdata,
  input  logic [lsu_pkg::axi_resp_w-1:0] rresp,
  input  logic                          rvalid,
  output logic                          arvalid,
  output logic [lsu_pkg::xlen-1:0]       araddr,
  output logic [2:0]                    arsize,
  output logic                          rready,
  output logic                          rd_done,
  output logic [lsu_pkg::xlen-1:0]       load_data
);
  import lsu_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_addr,
    st_data
  } rd_state_e;

  rd_state_e state;
  logic [xlen-1:0] shifted;
  logic [xlen-1:0] beat;

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle: if (rd_start) state <= st_addr;
        st_addr: if (arready) state <= st_data;  // AR transfer on this edge
        st_data: if (rvalid) state <= st_idle;
        default: state <= st_idle;
      endcase
    end
  end

  assign arvalid = (state == st_addr);
  assign rready  = (state == st_data);
  assign araddr  = op_addr;
  assign arsize  = axi_size(op_size);
  assign rd_done = rready & rvalid;

  // error responses complete the access but return zero data
  assign beat    = (rresp == resp_okay) ? rdata : '0;
  assign shifted = beat >> {op_addr[1:0], 3'b000};

  always_comb begin
    case (op_size)
      size_byte: load_data = {{(xlen - 8){op_sext & shifted[7]}}, shifted[7:0]};
      size_half: load_data = {{(xlen - 16){op_sext & shifted[15]}}, shifted[15:0]};
      default:   load_data = shifted;
    endcase
  end

endmodule

//--- lsu_stage.sv
`timescale 1ns/1ns

module lsu_stage (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    execute_valid,
  input  logic                    ren,
  input  logic                    wen,
  input  logic                    suffix_b,
  input  logic                    suffix_h,
  input  logic                    sext,
  input  logic                    clear_pipeline,
  input  logic [lsu_pkg::xlen-1:0] addr,
  input  logic [lsu_pkg::xlen-1:0] wsrc,
  input  logic [lsu_pkg::xlen-1:0] exu_pc,
  input  logic [lsu_pkg::xlen-1:0] exu_r_wdata,
  input  logic                    rd_done,
  input  logic                    wr_done,
  input  logic [lsu_pkg::xlen-1:0] load_data,
  output logic                    ls_valid,
  output logic                    block,
  output logic                    load_addr_misaligned,
  output logic                    store_addr_misaligned,
  output logic                    rd_start,
  output logic                    wr_start,
  output logic                    op_sext,
  output logic [lsu_pkg::xlen-1:0] lsu_pc,
  output logic [lsu_pkg::xlen-1:0] r_wdata,
  output logic [lsu_pkg::xlen-1:0] op_addr,
  output logic [lsu_pkg::xlen-1:0] op_wsrc,
  output lsu_pkg::mem_size_e      op_size
);
  import lsu_pkg::*;

  logic pend_rd;  // load registered, read channel not started yet
  logic pend_wr;
  logic in_flight;  // a channel owns the bus until its done pulse
  logic accept_mem;
  logic misaligned;

  assign accept_mem = execute_valid & (ren | wen) & ~clear_pipeline;

  // a half-word may cross lanes 0..2, only offset 3 spills into the next word
  always_comb begin
    case (op_size)
      size_byte: misaligned = 1'b0;
      size_half: misaligned = (op_addr[1:0] == 2'd3);
      default:   misaligned = (op_addr[1:0] != 2'd0);
    endcase
  end

  // ====================
  // operation registers
  // ====================

  always_ff @(posedge clock) begin
    if (!block) begin
      op_addr <= addr;
      op_wsrc <= wsrc;
      op_sext <= sext;
      op_size <= suffix_b ? size_byte : (suffix_h ? size_half : size_word);
      lsu_pc  <= exu_pc;
      r_wdata <= exu_r_wdata;
    end else if (rd_done) begin
      r_wdata <= load_data;  // extended load result replaces the pass-through value
    end
  end

  // ====================
  // control
  // ====================

  always_ff @(posedge clock) begin
    if (reset) begin
      ls_valid              <= 1'b0;
      block                 <= 1'b0;
      load_addr_misaligned  <= 1'b0;
      store_addr_misaligned <= 1'b0;
      rd_start              <= 1'b0;
      wr_start              <= 1'b0;
      pend_rd               <= 1'b0;
      pend_wr               <= 1'b0;
      in_flight             <= 1'b0;
    end else begin
      rd_start <= 1'b0;
      wr_start <= 1'b0;
      ls_valid <= 1'b0;
      if (!block) begin
        ls_valid <= execute_valid & ~ren & ~wen & ~clear_pipeline;
        block    <= accept_mem;
        pend_rd  <= accept_mem & ren;
        pend_wr  <= accept_mem & wen & ~ren;  // a load wins if both are set
      end else if (clear_pipeline && !in_flight) begin
        // flush drops a faulted or not yet started access
        block                 <= 1'b0;
        load_addr_misaligned  <= 1'b0;
        store_addr_misaligned <= 1'b0;
        pend_rd               <= 1'b0;
        pend_wr               <= 1'b0;
      end else begin
        if (pend_rd) begin
          pend_rd              <= 1'b0;
          load_addr_misaligned <= misaligned;
          rd_start             <= ~misaligned;
          in_flight            <= ~misaligned;
        end
        if (pend_wr) begin
          pend_wr               <= 1'b0;
          store_addr_misaligned <= misaligned;
          wr_start              <= ~misaligned;
          in_flight             <= ~misaligned;
        end
        if (rd_done || wr_done) begin
          in_flight <= 1'b0;
          block     <= 1'b0;
          ls_valid  <= 1'b1;
        end
      end
    end
  end

endmodule

//--- lsu_pkg.sv
package lsu_pkg;

  // ====================
  // widths
  // ====================

  localparam int xlen = 32;  // data and address width
  localparam int strb_w = xlen / 8;  // one strobe bit per byte lane
  localparam int axi_resp_w = 2;

  // ====================
  // data memory
  // ====================

  localparam int ram_words = 256;
  localparam int ram_aw = $clog2(ram_words);  // word index width, byte offset excluded

  localparam logic [axi_resp_w-1:0] resp_okay = 2'b00;

  // ====================
  // access size
  // ====================

  // encoded the same way as the low two bits of AXI arsize/awsize
  typedef enum logic [1:0] {
    size_byte = 2'd0,
    size_half = 2'd1,
    size_word = 2'd2
  } mem_size_e;

  // AXI size field for a single beat of the given access
  function automatic logic [2:0] axi_size(mem_size_e size);
    logic [2:0] code;
    case (size)
      size_byte: code = 3'd0;
      size_half: code = 3'd1;
      default:   code = 3'd2;
    endcase
    return code;
  endfunction

  // byte-lane mask of an access that starts at lane 0
  function automatic logic [strb_w-1:0] base_strobe(mem_size_e size);
    logic [strb_w-1:0] mask;
    case (size)
      size_byte: mask = strb_w'(4'b0001);
      size_half: mask = strb_w'(4'b0011);
      default:   mask = '1;
    endcase
    return mask;
  endfunction

endpackage
